// ==== verilog/ahb_lite_pkg.sv ====
// AHB-Lite encodings for a 32-bit bus only; no burst, lock or SEQ transfer types are defined
package ahb_lite_pkg;

  //////////////////////////////
  // Transfer control encodings
  //////////////////////////////

  // Only single transfers are issued, so BUSY and SEQ never appear
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10
  } htrans_t;

  // Transfer size, byte up to word
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  // Single transfer burst code
  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  // Data access, privileged, not bufferable, not cacheable
  localparam logic [3:0] HPROT_DBG_DATA = 4'b0011;

  //////////////////////////////
  // Bus word views
  //////////////////////////////

  // Lane 0 is HDATA[7:0] and half 0 is HDATA[15:0]
  typedef union packed {
    logic [3:0][7:0]  byte_lane;
    logic [1:0][15:0] half_lane;
  } ahb_word_u;

endpackage

// ==== verilog/dbg_biu_pkg.sv ====
// Debug size codes other than 1 and 2 are all treated as 32-bit word accesses
package dbg_biu_pkg;

  //////////////////////////////
  // Debug access size
  //////////////////////////////

  typedef logic [3:0] dbg_size_t;

  localparam dbg_size_t DBG_SIZE_BYTE = 4'h1;
  localparam dbg_size_t DBG_SIZE_HALF = 4'h2;
  localparam dbg_size_t DBG_SIZE_WORD = 4'h4;

  // Debug size code onto the AHB size field
  function automatic ahb_lite_pkg::hsize_t to_hsize(input dbg_size_t size);
    case (size)
      DBG_SIZE_BYTE: return ahb_lite_pkg::HSIZE_BYTE;
      DBG_SIZE_HALF: return ahb_lite_pkg::HSIZE_HWORD;
      DBG_SIZE_WORD: return ahb_lite_pkg::HSIZE_WORD;
      // Unknown codes fall back to a full word
      default:       return ahb_lite_pkg::HSIZE_WORD;
    endcase
  endfunction

  // Byte lane of an address within the bus word
  // Big endian mirrors the lane order
  function automatic logic [1:0] lane_index(input logic [1:0] addr_lo, input bit little_endian);
    return little_endian ? addr_lo : 2'd3 - addr_lo;
  endfunction

endpackage

// ==== verilog/dbg_toggle_sync.sv ====
// Input toggle must stay put for at least two clk cycles between changes, else edges are lost
`timescale 1ns/10ps

module dbg_toggle_sync (
  input  logic clk,
  input  logic rstn,
  input  logic tgl_in,
  output logic pulse
);

  // Two synchronizing stages plus a delayed copy for edge detection
  logic sync_1;
  logic sync_2;
  logic sync_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sync_1 <= 1'b0;
      sync_2 <= 1'b0;
      sync_q <= 1'b0;
    end else begin
      sync_1 <= tgl_in;
      sync_2 <= sync_1;
      sync_q <= sync_2;
    end
  end

  // Either edge of the synchronized toggle is one event
  assign pulse = sync_2 ^ sync_q;

  // One event never stretches over two cycles
  a_pulse_single : assert property (
    @(posedge clk) disable iff (!rstn)
    pulse |=> !pulse
  ) else $error("toggle sync pulse held for two cycles");

endmodule

// ==== verilog/dbg_biu_req.sv ====
// One request in flight; a strobe while biu_rdy is low is dropped without notice
`timescale 1ns/10ps

module dbg_biu_req #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                     biu_clk,
  input  logic                     ahb_rstn,
  input  logic                     biu_strb,
  input  logic                     biu_rw,
  input  logic [ADDR_WIDTH-1:0]    biu_addr,
  input  logic [31:0]              biu_di,
  input  dbg_biu_pkg::dbg_size_t   biu_word_size,
  input  logic                     done_pulse,
  output logic                     biu_rdy,
  output logic                     str_tgl,
  output logic [ADDR_WIDTH-1:0]    HADDR,
  output logic [31:0]              HWDATA,
  output logic                     HWRITE,
  output ahb_lite_pkg::hsize_t     HSIZE
);

  import dbg_biu_pkg::*;

  logic [1:0] rst_sync;
  logic       biu_rstn;
  logic       accept;

  //////////////////////////////
  // Reset release
  //////////////////////////////

  // Assert at once, release after two biu_clk edges
  always_ff @(posedge biu_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign biu_rstn = rst_sync[1];

  //////////////////////////////
  // Request capture
  //////////////////////////////

  assign accept = biu_strb & biu_rdy;

  // Address phase fields held for the whole transfer
  always_ff @(posedge biu_clk) begin
    if (accept) begin
      HADDR  <= biu_addr;
      // biu_rw high means read
      HWRITE <= ~biu_rw;
      HSIZE  <= to_hsize(biu_word_size);
    end
  end

  // Narrow write data sits in the top bits of biu_di
  // Copy it onto every lane so the slave finds it wherever it looks
  always_ff @(posedge biu_clk) begin
    if (accept) begin
      case (biu_word_size)
        DBG_SIZE_BYTE: HWDATA <= {4{biu_di[31:24]}};
        DBG_SIZE_HALF: HWDATA <= {2{biu_di[31:16]}};
        default:       HWDATA <= biu_di;
      endcase
    end
  end

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Toggle starts the transfer, done pulse reopens the port
  always_ff @(posedge biu_clk or negedge biu_rstn) begin
    if (!biu_rstn) begin
      str_tgl <= 1'b0;
      biu_rdy <= 1'b1;
    end else if (accept) begin
      str_tgl <= ~str_tgl;
      biu_rdy <= 1'b0;
    end else if (done_pulse) begin
      biu_rdy <= 1'b1;
    end
  end

  // Bus side samples HADDR and HWRITE across domains, they must not move mid transfer
  a_req_stable : assert property (
    @(posedge biu_clk) disable iff (!biu_rstn)
    !biu_rdy |=> $stable(HADDR) && $stable(HWRITE)
  ) else $error("request fields changed while busy");

endmodule

// ==== verilog/dbg_biu_ahb_master.sv ====
// Single NONSEQ transfers only; HADDR and HSIZE come from another domain and must be held
`timescale 1ns/10ps

module dbg_biu_ahb_master #(
  parameter int ADDR_WIDTH    = 32,
  parameter bit LITTLE_ENDIAN = 1'b1
) (
  input  logic                     HCLK,
  input  logic                     ahb_rstn,
  input  logic                     start_pulse,
  input  logic [ADDR_WIDTH-1:0]    HADDR,
  input  ahb_lite_pkg::hsize_t     HSIZE,
  input  logic [31:0]              HRDATA,
  input  logic                     HREADY,
  input  logic                     HRESP,
  output ahb_lite_pkg::htrans_t    HTRANS,
  output logic [31:0]              biu_do,
  output logic                     biu_err,
  output logic                     done_tgl
);

  import ahb_lite_pkg::*;
  import dbg_biu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  logic [1:0] rst_sync;
  logic       hrstn;
  state_t     state;
  logic       start_pend;
  logic       launch;
  logic       ack;
  ahb_word_u  rd_word;
  logic [1:0] rd_lane;
  logic [31:0] rd_ext;

  //////////////////////////////
  // Reset release
  //////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign hrstn = rst_sync[1];

  //////////////////////////////
  // Transfer FSM
  //////////////////////////////

  assign launch = (state == ST_IDLE) && start_pend;
  // Data phase ends on the first HREADY high
  assign ack    = (state == ST_DATA) && HREADY;

  // Start request waits here until the FSM is back in IDLE
  always_ff @(posedge HCLK or negedge hrstn) begin
    if (!hrstn) begin
      start_pend <= 1'b0;
    end else begin
      start_pend <= start_pulse | (start_pend & ~launch);
    end
  end

  always_ff @(posedge HCLK or negedge hrstn) begin
    if (!hrstn) begin
      state  <= ST_IDLE;
      HTRANS <= HTRANS_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_pend) begin
            HTRANS <= HTRANS_NONSEQ;
            state  <= ST_ADDR;
          end
        end
        // Address phase lasts exactly one cycle
        ST_ADDR: begin
          HTRANS <= HTRANS_IDLE;
          state  <= ST_DATA;
        end
        ST_DATA: begin
          if (HREADY) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          HTRANS <= HTRANS_IDLE;
          state  <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Read data and status
  //////////////////////////////

  assign rd_word = HRDATA;
  assign rd_lane = lane_index(HADDR[1:0], LITTLE_ENDIAN);

  // Pick the addressed lane and zero extend
  always_comb begin
    case (HSIZE)
      HSIZE_BYTE:  rd_ext = {24'h0, rd_word.byte_lane[rd_lane]};
      HSIZE_HWORD: rd_ext = {16'h0, rd_word.half_lane[rd_lane[1]]};
      default:     rd_ext = rd_word;
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (ack) begin
      biu_do <= rd_ext;
    end
  end

  // Status and completion toggle back to the debug side
  always_ff @(posedge HCLK or negedge hrstn) begin
    if (!hrstn) begin
      biu_err  <= 1'b0;
      done_tgl <= 1'b0;
    end else if (ack) begin
      biu_err  <= HRESP;
      done_tgl <= ~done_tgl;
    end
  end

  a_nonseq_once : assert property (
    @(posedge HCLK) disable iff (!hrstn)
    HTRANS == HTRANS_NONSEQ |=> HTRANS == HTRANS_IDLE
  ) else $error("NONSEQ held for more than one cycle");

endmodule

// ==== verilog/ahb_sram_slave.sv ====
// Single slave on the bus so HREADY is its own output; unwritten words read as zero in simulation
`timescale 1ns/10ps

module ahb_sram_slave #(
  parameter int ADDR_WIDTH    = 32,
  parameter bit LITTLE_ENDIAN = 1'b1,
  parameter int MEM_WORDS     = 256,
  parameter int WAIT_STATES   = 2
) (
  input  logic                     HCLK,
  input  logic                     ahb_rstn,
  input  ahb_lite_pkg::htrans_t    HTRANS,
  input  logic [ADDR_WIDTH-1:0]    HADDR,
  input  logic                     HWRITE,
  input  ahb_lite_pkg::hsize_t     HSIZE,
  input  logic [31:0]              HWDATA,
  output logic [31:0]              HRDATA,
  output logic                     HREADY,
  output logic                     HRESP
);

  import ahb_lite_pkg::*;
  import dbg_biu_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int WCW   = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  ahb_word_u        mem [MEM_WORDS];
  logic             addr_acc;
  logic             in_range;
  logic             dp_act;
  logic             dp_write;
  hsize_t           dp_size;
  logic [1:0]       dp_lo;
  logic [IDX_W-1:0] dp_idx;
  logic             err_tail;
  logic [WCW-1:0]   wait_cnt;
  logic [1:0]       lane;
  ahb_word_u        wdata;
  ahb_word_u        wr_word;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  assign addr_acc = (HTRANS == HTRANS_NONSEQ) && HREADY;
  assign in_range = HADDR[ADDR_WIDTH-1:2] < MEM_WORDS;

  always_ff @(posedge HCLK) begin
    if (addr_acc) begin
      dp_write <= HWRITE;
      dp_size  <= HSIZE;
      dp_lo    <= HADDR[1:0];
      dp_idx   <= HADDR[IDX_W+1:2];
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dp_act   <= 1'b0;
      err_tail <= 1'b0;
      wait_cnt <= '0;
      HREADY   <= 1'b1;
      HRESP    <= 1'b0;
    end else if (err_tail) begin
      // Second ERROR cycle keeps HRESP high
      err_tail <= 1'b0;
      HREADY   <= 1'b1;
    end else if (addr_acc && !in_range) begin
      dp_act   <= 1'b0;
      err_tail <= 1'b1;
      HREADY   <= 1'b0;
      HRESP    <= 1'b1;
    end else if (addr_acc) begin
      dp_act   <= 1'b1;
      wait_cnt <= WCW'(WAIT_STATES);
      HREADY   <= (WAIT_STATES == 0);
      HRESP    <= 1'b0;
    end else begin
      HRESP <= 1'b0;
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
        HREADY   <= (wait_cnt == WCW'(1));
      end else if (HREADY) begin
        dp_act <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  assign lane  = lane_index(dp_lo, LITTLE_ENDIAN);
  assign wdata = HWDATA;

  // Merge the selected lanes into the stored word
  always_comb begin
    wr_word = mem[dp_idx];
    case (dp_size)
      HSIZE_BYTE:  wr_word.byte_lane[lane] = wdata.byte_lane[lane];
      HSIZE_HWORD: wr_word.half_lane[lane[1]] = wdata.half_lane[lane[1]];
      default:     wr_word = wdata;
    endcase
  end

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Write lands on the last data phase cycle, when HWDATA is valid
  always @(posedge HCLK) begin
    if (dp_act && dp_write && HREADY) begin
      mem[dp_idx] <= wr_word;
    end
  end

  // Whole word goes back and the master picks its lane
  assign HRDATA = mem[dp_idx];

  a_err_two_cycle : assert property (
    @(posedge HCLK) disable iff (!ahb_rstn)
    (HRESP && !HREADY) |=> (HRESP && HREADY)
  ) else $error("ERROR response not completed in second cycle");

endmodule

// ==== verilog/dbg_ahb_sys.sv ====
// Debug unit and memory slave on a private AHB-Lite bus; both clocks may be unrelated
`timescale 1ns/10ps

module dbg_ahb_sys #(
  parameter int ADDR_WIDTH    = 32,
  parameter bit LITTLE_ENDIAN = 1'b1,
  parameter int MEM_WORDS     = 256,
  parameter int WAIT_STATES   = 2
) (
  input  logic                     biu_clk,
  input  logic                     HCLK,
  input  logic                     ahb_rstn,
  input  logic                     biu_strb,
  input  logic                     biu_rw,
  input  logic [ADDR_WIDTH-1:0]    biu_addr,
  input  logic [31:0]              biu_di,
  input  dbg_biu_pkg::dbg_size_t   biu_word_size,
  output logic                     biu_rdy,
  output logic [31:0]              biu_do,
  output logic                     biu_err,
  output ahb_lite_pkg::htrans_t    HTRANS
);

  import ahb_lite_pkg::*;

  logic                  str_tgl;
  logic                  start_pulse;
  logic                  done_tgl;
  logic                  done_pulse;
  logic [ADDR_WIDTH-1:0] HADDR;
  logic [31:0]           HWDATA;
  logic [31:0]           HRDATA;
  logic                  HWRITE;
  hsize_t                HSIZE;
  logic                  HREADY;
  logic                  HRESP;
  logic [2:0]            HBURST;
  logic [3:0]            HPROT;
  logic                  HMASTLOCK;

  // Fixed bus attributes of every debug access
  assign HBURST    = HBURST_SINGLE;
  assign HPROT     = HPROT_DBG_DATA;
  assign HMASTLOCK = 1'b0;

  dbg_biu_req #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_biu_req (
    .biu_clk       (biu_clk),
    .ahb_rstn      (ahb_rstn),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_addr      (biu_addr),
    .biu_di        (biu_di),
    .biu_word_size (biu_word_size),
    .done_pulse    (done_pulse),
    .biu_rdy       (biu_rdy),
    .str_tgl       (str_tgl),
    .HADDR         (HADDR),
    .HWDATA        (HWDATA),
    .HWRITE        (HWRITE),
    .HSIZE         (HSIZE)
  );

  // Toggles sit low through reset, so raw reset release is harmless here
  dbg_toggle_sync i_start_sync (
    .clk    (HCLK),
    .rstn   (ahb_rstn),
    .tgl_in (str_tgl),
    .pulse  (start_pulse)
  );

  dbg_toggle_sync i_done_sync (
    .clk    (biu_clk),
    .rstn   (ahb_rstn),
    .tgl_in (done_tgl),
    .pulse  (done_pulse)
  );

  dbg_biu_ahb_master #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .LITTLE_ENDIAN (LITTLE_ENDIAN)
  ) i_ahb_master (
    .HCLK        (HCLK),
    .ahb_rstn    (ahb_rstn),
    .start_pulse (start_pulse),
    .HADDR       (HADDR),
    .HSIZE       (HSIZE),
    .HRDATA      (HRDATA),
    .HREADY      (HREADY),
    .HRESP       (HRESP),
    .HTRANS      (HTRANS),
    .biu_do      (biu_do),
    .biu_err     (biu_err),
    .done_tgl    (done_tgl)
  );

  ahb_sram_slave #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .LITTLE_ENDIAN (LITTLE_ENDIAN),
    .MEM_WORDS     (MEM_WORDS),
    .WAIT_STATES   (WAIT_STATES)
  ) i_sram_slave (
    .HCLK     (HCLK),
    .ahb_rstn (ahb_rstn),
    .HTRANS   (HTRANS),
    .HADDR    (HADDR),
    .HWRITE   (HWRITE),
    .HSIZE    (HSIZE),
    .HWDATA   (HWDATA),
    .HRDATA   (HRDATA),
    .HREADY   (HREADY),
    .HRESP    (HRESP)
  );

endmodule

// ==== sim/tb_clkgen.sv ====
// Free running clock for simulation only; starts low and runs until the simulation finishes
`timescale 1ns/10ps

module tb_clkgen #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);

  // Half period per phase, first rising edge after half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

// ==== sim/tb_dbg_ahb_sys.sv ====
// Runs one parameter set only (little endian, 256 words, 2 wait states); stops at the first error
`timescale 1ns/10ps

module tb_dbg_ahb_sys;

  localparam int ADDR_WIDTH    = 32;
  localparam bit LITTLE_ENDIAN = 1'b1;
  localparam int MEM_WORDS     = 256;
  localparam int WAIT_STATES   = 2;
  // biu_clk cycles allowed for one access
  localparam int RDY_TIMEOUT   = 200;
  localparam int MIX_COUNT     = 400;

  logic                  hclk;
  logic                  biu_clk;
  logic                  ahb_rstn;
  logic                  biu_strb;
  logic                  biu_rw;
  logic [ADDR_WIDTH-1:0] biu_addr;
  logic [31:0]           biu_di;
  logic [3:0]            biu_word_size;
  logic                  biu_rdy;
  logic [31:0]           biu_do;
  logic                  biu_err;
  logic [1:0]            htrans;

  // Reference memory with one entry per byte lane
  logic [7:0] model_mem [MEM_WORDS*4];

  tb_clkgen #(.PERIOD_NS(10.0)) i_hclk_gen (.clk(hclk));
  tb_clkgen #(.PERIOD_NS(26.0)) i_biu_clk_gen (.clk(biu_clk));

  dbg_ahb_sys #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .LITTLE_ENDIAN (LITTLE_ENDIAN),
    .MEM_WORDS     (MEM_WORDS),
    .WAIT_STATES   (WAIT_STATES)
  ) i_dbg_ahb_sys (
    .biu_clk       (biu_clk),
    .HCLK          (hclk),
    .ahb_rstn      (ahb_rstn),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_addr      (biu_addr),
    .biu_di        (biu_di),
    .biu_word_size (biu_word_size),
    .biu_rdy       (biu_rdy),
    .biu_do        (biu_do),
    .biu_err       (biu_err),
    .HTRANS        (htrans)
  );

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic bit in_range(input logic [31:0] addr);
    return (addr >> 2) < MEM_WORDS;
  endfunction

  // Narrow data comes from the top of di and big endian mirrors the lane order
  task automatic model_write(input logic [31:0] addr, input logic [31:0] di,
                             input logic [3:0] size);
    int         base;
    logic [1:0] lane;
    base = int'(addr >> 2) * 4;
    lane = LITTLE_ENDIAN ? addr[1:0] : ~addr[1:0];
    if (size == 4'h1) begin
      model_mem[base + lane] = di[31:24];
    end else if (size == 4'h2) begin
      model_mem[base + {lane[1], 1'b0}] = di[23:16];
      model_mem[base + {lane[1], 1'b1}] = di[31:24];
    end else begin
      model_mem[base]     = di[7:0];
      model_mem[base + 1] = di[15:8];
      model_mem[base + 2] = di[23:16];
      model_mem[base + 3] = di[31:24];
    end
  endtask

  // Selected lane zero extended
  function automatic logic [31:0] model_read(input logic [31:0] addr, input logic [3:0] size);
    int         base;
    logic [1:0] lane;
    base = int'(addr >> 2) * 4;
    lane = LITTLE_ENDIAN ? addr[1:0] : ~addr[1:0];
    if (size == 4'h1) begin
      return {24'h0, model_mem[base + lane]};
    end else if (size == 4'h2) begin
      return {16'h0, model_mem[base + {lane[1], 1'b1}], model_mem[base + {lane[1], 1'b0}]};
    end
    return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Mostly legal codes and now and then an odd code that must act as a word
  function automatic logic [3:0] random_size();
    case ($urandom % 4)
      0:       return 4'h1;
      1:       return 4'h2;
      2:       return 4'h4;
      default: return 4'($urandom % 16);
    endcase
  endfunction

  function automatic logic [31:0] random_addr(input bit allow_bad);
    if (allow_bad && ($urandom % 8 == 0)) begin
      return MEM_WORDS * 4 + ($urandom % 4096);
    end
    return $urandom % (MEM_WORDS * 4);
  endfunction

  // Called 1 ns after a biu_clk edge with biu_rdy high
  // poke_busy adds a write strobe right after acceptance, which must be dropped
  task automatic run_access(input logic rw, input logic [31:0] addr, input logic [31:0] di,
                            input logic [3:0] size, input bit poke_busy,
                            output logic [31:0] rdata, output logic err);
    int cycles;
    cycles = 0;
    biu_strb      = 1'b1;
    biu_rw        = rw;
    biu_addr      = addr;
    biu_di        = di;
    biu_word_size = size;
    @(posedge biu_clk);
    #1;
    // Accepted on that edge
    check_value("biu_rdy", {31'h0, biu_rdy}, 32'h0);
    if (poke_busy) begin
      biu_rw        = 1'b0;
      biu_di        = ~di;
      biu_word_size = 4'h4;
      @(posedge biu_clk);
      #1;
    end
    biu_strb = 1'b0;
    while (!biu_rdy) begin
      if (cycles >= RDY_TIMEOUT) begin
        stop_on_error("biu_rdy did not return high within the timeout");
      end
      @(posedge biu_clk);
      #1;
      cycles++;
    end
    rdata = biu_do;
    err   = biu_err;
  endtask

  // One access, model update and checks of biu_err and read data
  task automatic access_and_check(input logic rw, input logic [31:0] addr,
                                  input logic [31:0] di, input logic [3:0] size);
    logic [31:0] rdata;
    logic        err;
    bit          valid;
    valid = in_range(addr);
    run_access(rw, addr, di, size, 1'b0, rdata, err);
    check_value("biu_err", {31'h0, err}, {31'h0, !valid});
    if (valid && !rw) begin
      model_write(addr, di, size);
    end
    if (valid && rw) begin
      check_value("biu_do", rdata, model_read(addr, size));
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] word_addrs [20];
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    logic [3:0]  size;
    logic        err;

    void'($urandom(32'h26db));
    ahb_rstn      = 1'b0;
    biu_strb      = 1'b0;
    biu_rw        = 1'b1;
    biu_addr      = '0;
    biu_di        = '0;
    biu_word_size = 4'h4;
    // Slave memory starts out cleared
    for (int i = 0; i < MEM_WORDS * 4; i++) begin
      model_mem[i] = 8'h00;
    end

    repeat (10) @(posedge hclk);
    #1;
    ahb_rstn = 1'b1;
    // Let both release synchronizers settle
    repeat (4) @(posedge biu_clk);
    #1;

    // Idle state after reset
    check_value("biu_rdy", {31'h0, biu_rdy}, 32'h1);
    check_value("biu_err", {31'h0, biu_err}, 32'h0);
    check_value("HTRANS", {30'h0, htrans}, 32'h0);

    // Word writes then read back
    for (int i = 0; i < 20; i++) begin
      word_addrs[i] = ($urandom % MEM_WORDS) * 4;
      access_and_check(1'b0, word_addrs[i], $urandom, 4'h4);
    end
    for (int i = 0; i < 20; i++) begin
      access_and_check(1'b1, word_addrs[i], 32'h0, 4'h4);
    end

    // Byte and halfword lanes, read narrow and as a whole word
    for (int i = 0; i < 40; i++) begin
      addr = random_addr(1'b0);
      size = (i % 2 == 0) ? 4'h1 : 4'h2;
      access_and_check(1'b0, addr, $urandom, size);
      access_and_check(1'b1, addr, 32'h0, size);
      access_and_check(1'b1, addr, 32'h0, 4'h4);
    end

    // Out of range accesses including the first word past the end
    for (int i = 0; i < 6; i++) begin
      addr = (i == 0) ? MEM_WORDS * 4 : MEM_WORDS * 4 + ($urandom % 65536);
      data = addr % (MEM_WORDS * 4);
      // Seed the aliased word so a stray write would show up
      access_and_check(1'b0, data, $urandom, 4'h4);
      access_and_check(1'b0, addr, $urandom, random_size());
      access_and_check(1'b1, addr, 32'h0, 4'h4);
      // Valid access clears biu_err and sees the old data
      access_and_check(1'b1, data, 32'h0, 4'h4);
    end

    // Strobe while busy writes inverted data to the same word
    for (int i = 0; i < 8; i++) begin
      addr = ($urandom % MEM_WORDS) * 4;
      data = $urandom;
      run_access(1'b0, addr, data, 4'h4, 1'b1, rdata, err);
      check_value("biu_err", {31'h0, err}, 32'h0);
      model_write(addr, data, 4'h4);
      access_and_check(1'b1, addr, 32'h0, 4'h4);
    end

    // Long random mix
    for (int i = 0; i < MIX_COUNT; i++) begin
      access_and_check(1'($urandom % 2), random_addr(1'b1), $urandom, random_size());
    end

    $display("sim passed");
    $finish;
  end

endmodule

// ==== dbg_ahb.f ====
verilog/ahb_lite_pkg.sv
verilog/dbg_biu_pkg.sv
verilog/dbg_toggle_sync.sv
verilog/dbg_biu_req.sv
verilog/dbg_biu_ahb_master.sv
verilog/ahb_sram_slave.sv
verilog/dbg_ahb_sys.sv
sim/tb_clkgen.sv
sim/tb_dbg_ahb_sys.sv
